// File: source/ssio_link_pkg.sv
// SSIO link shared definitions
package ssio_link_pkg;

    // link word and buffer geometry
    localparam int LINK_W   = 10;
    localparam int RX_DEPTH = 16;
    // must hold 0 to RX_DEPTH
    localparam int CREDIT_W = 5;

    typedef logic [7:0] data_t;

    typedef enum logic [2:0] {
        CODE_IDLE   = 3'd0,
        CODE_CREDIT = 3'd1
    } ctrl_code_e;

    // same 10 bits seen as data or control, selected by k
    typedef union packed {
        struct packed {
            logic  k;
            logic  parity;
            data_t data;
        } dat;
        struct packed {
            logic       k;
            ctrl_code_e code;
            logic [5:0] count;
        } ctl;
    } link_word_u;

    // filler when there is nothing to send
    localparam link_word_u IDLE_WORD = link_word_u'({1'b1, CODE_IDLE, 6'd0});

endpackage

// File: source/ssio_sdr_out_diff.sv
// Differential SDR output stage
module ssio_sdr_out_diff #(
    // use generic logic instead of vendor buffers
    parameter logic SIM = 1'b0,
    // "GENERIC", "XILINX" or "ALTERA"
    parameter string VENDOR = "XILINX",
    parameter int WIDTH = 1
) (
    input  logic             clk,
    input  logic [WIDTH-1:0] input_d,
    output logic             output_clk_p,
    output logic             output_clk_n,
    output logic [WIDTH-1:0] output_q_p,
    output logic [WIDTH-1:0] output_q_n
);

    logic             output_clk;
    logic [WIDTH-1:0] output_q;

    // single data-rate launch register
    always_ff @(posedge clk) begin
        output_q <= input_d;
    end

    // inverted clock puts the forwarded edge in the middle of the bit
    assign output_clk = ~clk;

    // true and complement levels driven directly
    assign output_clk_p = output_clk;
    assign output_clk_n = ~output_clk;
    assign output_q_p   = output_q;
    assign output_q_n   = ~output_q;

endmodule

// File: source/ssio_sdr_in_diff.sv
// Differential SDR input stage
module ssio_sdr_in_diff #(
    // use generic logic instead of vendor buffers
    parameter logic SIM = 1'b0,
    // "GENERIC", "XILINX" or "ALTERA"
    parameter string VENDOR = "XILINX",
    parameter int WIDTH = 1
) (
    input  logic             clk,
    input  logic [WIDTH-1:0] input_p,
    input  logic [WIDTH-1:0] input_n,
    output logic [WIDTH-1:0] output_q
);

    logic [WIDTH-1:0] input_se;

    // follows p while the pair is driven differentially
    assign input_se = input_p & ~input_n;

    // capture on the local clock, no recovered clock in this endpoint
    always_ff @(posedge clk) begin
        output_q <= input_se;
    end

endmodule

// File: source/link_framer.sv
// Link transmit framer
module link_framer (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                enable,
    input  ssio_link_pkg::data_t                tx_data,
    input  logic                                tx_valid,
    output logic                                tx_ready,
    input  logic [5:0]                          peer_credit,
    input  logic                                peer_credit_valid,
    input  logic                                freed,
    input  logic                                drop,
    output logic [ssio_link_pkg::CREDIT_W-1:0]  credits,
    output ssio_link_pkg::link_word_u           word
);

    import ssio_link_pkg::*;

    logic [CREDIT_W-1:0] pending;
    logic                send_credit;
    logic                accept;
    link_word_u          word_next;

    // credit return always wins over data
    assign send_credit = (pending != '0);

    assign tx_ready = enable && (credits != '0) && !send_credit;
    assign accept   = tx_valid && tx_ready;

    // word selection
    always_comb begin
        word_next = IDLE_WORD;
        if (send_credit) begin
            word_next.ctl.k     = 1'b1;
            word_next.ctl.code  = CODE_CREDIT;
            word_next.ctl.count = 6'(pending);
        end else if (accept) begin
            word_next.dat.k      = 1'b0;
            // even parity over data and parity bit
            word_next.dat.parity = ^tx_data;
            word_next.dat.data   = tx_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            word <= IDLE_WORD;
        end else begin
            word <= word_next;
        end
    end

    // peer buffer credits, starts at the peer's full depth
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CREDIT_W'(RX_DEPTH);
        end else begin
            credits <= credits
                     + (peer_credit_valid ? CREDIT_W'(peer_credit) : '0)
                     - CREDIT_W'(accept);
        end
    end

    // credits owed back to the peer, popped or dropped entries
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
        end else if (send_credit) begin
            // whole balance goes out this cycle
            pending <= CREDIT_W'(freed) + CREDIT_W'(drop);
        end else begin
            pending <= pending + CREDIT_W'(freed) + CREDIT_W'(drop);
        end
    end

endmodule

// File: source/link_deframer.sv
// Link receive deframer
module link_deframer (
    input  logic                        clk,
    input  logic                        rst,
    input  ssio_link_pkg::link_word_u   word,
    output ssio_link_pkg::data_t        wr_data,
    output logic                        wr_en,
    output logic                        drop,
    output logic [5:0]                  peer_credit,
    output logic                        peer_credit_valid,
    output logic                        parity_err
);

    import ssio_link_pkg::*;

    logic is_data;
    logic parity_ok;
    logic is_credit;

    // k picks the view
    assign is_data   = !word.dat.k;
    assign parity_ok = ~^{word.dat.parity, word.dat.data};
    assign is_credit = word.ctl.k && (word.ctl.code == CODE_CREDIT);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_en             <= 1'b0;
            drop              <= 1'b0;
            parity_err        <= 1'b0;
            peer_credit_valid <= 1'b0;
        end else begin
            wr_en             <= is_data && parity_ok;
            // bad word still frees its credit at the peer
            drop              <= is_data && !parity_ok;
            parity_err        <= is_data && !parity_ok;
            peer_credit_valid <= is_credit;
        end
    end

    // payload fields
    always_ff @(posedge clk) begin
        wr_data     <= word.dat.data;
        peer_credit <= word.ctl.count;
    end

endmodule

// File: source/rx_buffer.sv
// Receive FIFO with credit return
module rx_buffer (
    input  logic                    clk,
    input  logic                    rst,
    input  ssio_link_pkg::data_t    wr_data,
    input  logic                    wr_en,
    output ssio_link_pkg::data_t    rx_data,
    output logic                    rx_valid,
    input  logic                    rx_ready,
    output logic                    freed
);

    import ssio_link_pkg::*;

    data_t                      mem [RX_DEPTH];
    logic [$clog2(RX_DEPTH):0]  wr_ptr;
    logic [$clog2(RX_DEPTH):0]  rd_ptr;
    logic                       empty;
    logic                       load;

    assign empty = (wr_ptr == rd_ptr);
    // refill the output register when it is free or being popped
    assign load  = !empty && (!rx_valid || rx_ready);
    assign freed = rx_valid && rx_ready;

    // no full check, the peer never sends beyond its credits
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[$clog2(RX_DEPTH)-1:0]] <= wr_data;
        end
        if (load) begin
            rx_data <= mem[rd_ptr[$clog2(RX_DEPTH)-1:0]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            rx_valid <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (load) begin
                rd_ptr   <= rd_ptr + 1'b1;
                rx_valid <= 1'b1;
            end else if (rx_ready) begin
                rx_valid <= 1'b0;
            end
        end
    end

endmodule

// File: source/link_regs.sv
// Link control and status registers
module link_regs (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [1:0]                          reg_addr,
    input  logic [7:0]                          reg_wdata,
    input  logic                                reg_we,
    output logic [7:0]                          reg_rdata,
    input  logic [ssio_link_pkg::CREDIT_W-1:0]  credits,
    input  logic                                parity_err,
    output logic                                enable
);

    logic [7:0] err_cnt;

    // control register, bit 0 enables transmit
    always_ff @(posedge clk) begin
        if (rst) begin
            enable <= 1'b0;
        end else if (reg_we && reg_addr == 2'd0) begin
            enable <= reg_wdata[0];
        end
    end

    // saturating error count, any write clears it
    always_ff @(posedge clk) begin
        if (rst) begin
            err_cnt <= '0;
        end else if (reg_we && reg_addr == 2'd2) begin
            err_cnt <= '0;
        end else if (parity_err && err_cnt != 8'hff) begin
            err_cnt <= err_cnt + 8'd1;
        end
    end

    // read mux
    always_comb begin
        case (reg_addr)
            2'd0:    reg_rdata = {7'd0, enable};
            2'd1:    reg_rdata = 8'(credits);
            2'd2:    reg_rdata = err_cnt;
            default: reg_rdata = 8'd0;
        endcase
    end

endmodule

// File: source/ssio_link_top.sv
// SSIO link endpoint
module ssio_link_top (
    input  logic                                clk,
    input  logic                                rst,
    input  ssio_link_pkg::data_t                tx_data,
    input  logic                                tx_valid,
    output logic                                tx_ready,
    output ssio_link_pkg::data_t                rx_data,
    output logic                                rx_valid,
    input  logic                                rx_ready,
    input  logic [1:0]                          reg_addr,
    input  logic [7:0]                          reg_wdata,
    input  logic                                reg_we,
    output logic [7:0]                          reg_rdata,
    output logic                                link_clk_p,
    output logic                                link_clk_n,
    output logic [ssio_link_pkg::LINK_W-1:0]    link_q_p,
    output logic [ssio_link_pkg::LINK_W-1:0]    link_q_n,
    input  logic [ssio_link_pkg::LINK_W-1:0]    link_d_p,
    input  logic [ssio_link_pkg::LINK_W-1:0]    link_d_n
);

    import ssio_link_pkg::*;

    link_word_u             tx_word;
    link_word_u             rx_word;
    logic                   enable;
    logic [CREDIT_W-1:0]    credits;
    logic [5:0]             peer_credit;
    logic                   peer_credit_valid;
    logic                   freed;
    logic                   drop;
    logic                   parity_err;
    data_t                  wr_data;
    logic                   wr_en;

    // transmit lane
    link_framer framer_inst (
        .clk(clk), .rst(rst), .enable(enable),
        .tx_data(tx_data), .tx_valid(tx_valid), .tx_ready(tx_ready),
        .peer_credit(peer_credit), .peer_credit_valid(peer_credit_valid),
        .freed(freed), .drop(drop), .credits(credits), .word(tx_word)
    );

    ssio_sdr_out_diff #(.SIM(1'b1), .VENDOR("GENERIC"), .WIDTH(LINK_W)) sdr_out_inst (
        .clk(clk), .input_d(tx_word),
        .output_clk_p(link_clk_p), .output_clk_n(link_clk_n),
        .output_q_p(link_q_p), .output_q_n(link_q_n)
    );

    // receive lane
    ssio_sdr_in_diff #(.SIM(1'b1), .VENDOR("GENERIC"), .WIDTH(LINK_W)) sdr_in_inst (
        .clk(clk), .input_p(link_d_p), .input_n(link_d_n), .output_q(rx_word)
    );

    link_deframer deframer_inst (
        .clk(clk), .rst(rst), .word(rx_word),
        .wr_data(wr_data), .wr_en(wr_en), .drop(drop),
        .peer_credit(peer_credit), .peer_credit_valid(peer_credit_valid),
        .parity_err(parity_err)
    );

    rx_buffer rx_buffer_inst (
        .clk(clk), .rst(rst), .wr_data(wr_data), .wr_en(wr_en),
        .rx_data(rx_data), .rx_valid(rx_valid), .rx_ready(rx_ready), .freed(freed)
    );

    link_regs regs_inst (
        .clk(clk), .rst(rst), .reg_addr(reg_addr), .reg_wdata(reg_wdata),
        .reg_we(reg_we), .reg_rdata(reg_rdata), .credits(credits),
        .parity_err(parity_err), .enable(enable)
    );

endmodule

// File: testbench/tb_ssio_link.sv
// SSIO link loopback testbench
module tb_ssio_link;

    import ssio_link_pkg::*;

    localparam int TIMEOUT = 1000;

    logic              clk;
    logic              rst;
    data_t             tx_data;
    logic              tx_valid;
    logic              tx_ready;
    data_t             rx_data;
    logic              rx_valid;
    logic              rx_ready;
    logic [1:0]        reg_addr;
    logic [7:0]        reg_wdata;
    logic              reg_we;
    logic [7:0]        reg_rdata;
    logic              link_clk_p;
    logic              link_clk_n;
    logic [LINK_W-1:0] link_q_p;
    logic [LINK_W-1:0] link_q_n;
    logic [LINK_W-1:0] link_d_p;
    logic [LINK_W-1:0] link_d_n;
    logic [LINK_W-1:0] flip_mask;
    logic              arm_inject;
    logic              inject_armed;
    data_t             to_send[$];
    data_t             expected[$];

    ssio_link_top dut (
        .clk(clk), .rst(rst),
        .tx_data(tx_data), .tx_valid(tx_valid), .tx_ready(tx_ready),
        .rx_data(rx_data), .rx_valid(rx_valid), .rx_ready(rx_ready),
        .reg_addr(reg_addr), .reg_wdata(reg_wdata), .reg_we(reg_we), .reg_rdata(reg_rdata),
        .link_clk_p(link_clk_p), .link_clk_n(link_clk_n),
        .link_q_p(link_q_p), .link_q_n(link_q_n),
        .link_d_p(link_d_p), .link_d_n(link_d_n)
    );

    // loopback, flips data bit 0 of the first data word seen while armed
    assign flip_mask = (inject_armed && !link_q_p[LINK_W-1]) ? {{(LINK_W-1){1'b0}}, 1'b1} : '0;
    assign link_d_p  = link_q_p ^ flip_mask;
    assign link_d_n  = link_q_n ^ flip_mask;

    always @(posedge clk) begin
        if (rst) begin
            inject_armed <= 1'b0;
        end else if (arm_inject) begin
            inject_armed <= 1'b1;
        end else if (flip_mask != '0) begin
            inject_armed <= 1'b0;
        end
    end

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_byte(input data_t got, input data_t exp, input string what);
        if (got !== exp) begin
            stop_with_error($sformatf("[FAIL] %0t %s: got %02h, expected %02h",
                                      $time, what, got, exp));
        end
    endtask

    task automatic check_reg(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            stop_with_error($sformatf("[FAIL] %0t %s: got %0d, expected %0d",
                                      $time, what, got, exp));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_with_error($sformatf("[FAIL] %0t %s: got %b, expected %b",
                                      $time, what, got, exp));
        end
    endtask

    task automatic check_word(input link_word_u got, input link_word_u exp, input string what);
        if (got !== exp) begin
            stop_with_error($sformatf("[FAIL] %0t %s: got %03h, expected %03h",
                                      $time, what, got, exp));
        end
    endtask

    // forwarded clock is the inverse of clk, each pair complementary
    task automatic check_pins();
        @(negedge clk);
        #5;
        check_bit(link_clk_p, 1'b1, "link_clk_p with clk low");
        check_bit(link_clk_n, 1'b0, "link_clk_n with clk low");
        check_word(~link_q_n, IDLE_WORD, "inverted link_q_n after reset");
        @(posedge clk);
        #5;
        check_bit(link_clk_p, 1'b0, "link_clk_p with clk high");
        check_bit(link_clk_n, 1'b1, "link_clk_n with clk high");
    endtask

    // caller hands over right after a rising edge
    task automatic send_byte(input data_t b);
        int waited = 0;
        @(posedge clk);
        tx_data  <= b;
        tx_valid <= 1'b1;
        @(negedge clk);
        while (!tx_ready) begin
            waited++;
            if (waited > TIMEOUT) begin
                stop_with_error("timeout: tx_ready never rose to take a byte");
            end
            @(negedge clk);
        end
        // taken on this edge
        @(posedge clk);
        tx_valid <= 1'b0;
    endtask

    task automatic recv_byte(output data_t b);
        int waited = 0;
        @(negedge clk);
        while (!rx_valid) begin
            waited++;
            if (waited > TIMEOUT) begin
                stop_with_error("timeout: no byte arrived on the receive side");
            end
            @(negedge clk);
        end
        b = rx_data;
        @(posedge clk);
    endtask

    task automatic send_queue(input int n);
        repeat (n) send_byte(to_send.pop_front());
    endtask

    task automatic receive_expected(input int n);
        data_t got;
        for (int i = 0; i < n; i++) begin
            recv_byte(got);
            check_byte(got, expected.pop_front(), $sformatf("received byte %0d", i));
        end
    endtask

    task automatic queue_random(input int n, input int skip);
        data_t b;
        for (int i = 0; i < n; i++) begin
            b = 8'($urandom);
            to_send.push_back(b);
            if (i >= skip) begin
                expected.push_back(b);
            end
        end
    endtask

    task automatic write_reg(input logic [1:0] addr, input logic [7:0] value);
        @(posedge clk);
        reg_addr  <= addr;
        reg_wdata <= value;
        reg_we    <= 1'b1;
        @(posedge clk);
        reg_we    <= 1'b0;
    endtask

    task automatic read_reg(input logic [1:0] addr, output logic [7:0] value);
        @(posedge clk);
        reg_addr <= addr;
        reg_we   <= 1'b0;
        @(negedge clk);
        value = reg_rdata;
    endtask

    task automatic wait_credits_full();
        logic [7:0] value;
        int         waited = 0;
        read_reg(2'd1, value);
        while (value != 8'(RX_DEPTH)) begin
            waited++;
            if (waited > TIMEOUT) begin
                stop_with_error("timeout: credit count never returned to full");
            end
            read_reg(2'd1, value);
        end
    endtask

    task automatic watch_low(input logic watch_tx, input logic watch_rx, input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            if (watch_tx) begin
                check_bit(tx_ready, 1'b0, "tx_ready");
            end
            if (watch_rx) begin
                check_bit(rx_valid, 1'b0, "rx_valid");
            end
        end
    endtask

    task automatic test_reset_state();
        logic [7:0] value;
        watch_low(1'b1, 1'b1, 10);
        check_word(link_q_p, IDLE_WORD, "link word after reset");
        check_pins();
        read_reg(2'd1, value);
        check_reg(value, 8'(RX_DEPTH), "credits after reset");
        read_reg(2'd2, value);
        check_reg(value, 8'd0, "error count after reset");
    endtask

    task automatic test_streaming();
        logic [7:0] value;
        write_reg(2'd0, 8'h01);
        rx_ready <= 1'b1;
        queue_random(40, 0);
        read_reg(2'd0, value);
        check_reg(value, 8'h01, "control register after enable");
        fork
            send_queue(40);
            receive_expected(40);
        join
        wait_credits_full();
    endtask

    task automatic test_back_pressure();
        logic [7:0] value;
        @(posedge clk);
        rx_ready <= 1'b0;
        queue_random(RX_DEPTH, 0);
        send_queue(RX_DEPTH);
        watch_low(1'b1, 1'b0, 30);
        read_reg(2'd1, value);
        check_reg(value, 8'd0, "credits with receive buffer full");
        @(posedge clk);
        rx_ready <= 1'b1;
        receive_expected(RX_DEPTH);
        wait_credits_full();
    endtask

    task automatic test_parity_error();
        logic [7:0] value;
        // first byte is corrupted on the wire and must not arrive
        queue_random(4, 1);
        @(posedge clk);
        arm_inject <= 1'b1;
        @(posedge clk);
        arm_inject <= 1'b0;
        fork
            send_queue(4);
            receive_expected(3);
        join
        read_reg(2'd2, value);
        check_reg(value, 8'd1, "error count after corrupted word");
        wait_credits_full();
        write_reg(2'd2, 8'h00);
        read_reg(2'd2, value);
        check_reg(value, 8'd0, "error count after clear");
    endtask

    task automatic test_disable();
        @(posedge clk);
        rx_ready <= 1'b0;
        queue_random(3, 0);
        send_queue(3);
        write_reg(2'd0, 8'h00);
        // offer one more byte that must be refused
        tx_data  <= 8'($urandom);
        tx_valid <= 1'b1;
        watch_low(1'b1, 1'b0, 20);
        @(posedge clk);
        tx_valid <= 1'b0;
        rx_ready <= 1'b1;
        receive_expected(3);
        watch_low(1'b0, 1'b1, 30);
    endtask

    initial begin
        void'($urandom(32'h4cd9));
        rst        <= 1'b1;
        tx_data    <= '0;
        tx_valid   <= 1'b0;
        rx_ready   <= 1'b0;
        reg_addr   <= '0;
        reg_wdata  <= '0;
        reg_we     <= 1'b0;
        arm_inject <= 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        test_reset_state();
        test_streaming();
        test_back_pressure();
        test_parity_error();
        test_disable();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: list.f
source/ssio_link_pkg.sv
source/ssio_sdr_out_diff.sv
source/ssio_sdr_in_diff.sv
source/link_framer.sv
source/link_deframer.sv
source/rx_buffer.sv
source/link_regs.sv
source/ssio_link_top.sv
testbench/tb_ssio_link.sv

// File: Bender.yml
package:
  name: ssio_link

sources:
  - files:
      - source/ssio_link_pkg.sv
      - source/ssio_sdr_out_diff.sv
      - source/ssio_sdr_in_diff.sv
      - source/link_framer.sv
      - source/link_deframer.sv
      - source/rx_buffer.sv
      - source/link_regs.sv
      - source/ssio_link_top.sv
  - target: test
    files:
      - testbench/tb_ssio_link.sv
